// ==== sources.f ====
src/csr_pkg.sv
src/csr_access_check.sv
src/machine_trap_csrs.sv
src/hpm_counters.sv
src/csr_read_mux.sv
src/csr_file.sv
verification/tb_clock_gen.sv
verification/csr_file_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module csr_file_tb -o csr_file_sim &&
./obj_dir/csr_file_sim | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verification/csr_file_tb.sv ====
// Random-access testbench for the CSR file with a register model
// One access slot per cycle, read value and invalid flag checked before each edge
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb import csr_pkg::*; ();

  localparam csr_word_t TB_HARTID      = 32'h0000_0005;
  localparam int        NUM_ACCESSES   = 2000;
  localparam int        TIMEOUT_CYCLES = NUM_ACCESSES + 100; // Reset and slack on top
  localparam int        NUM_KNOWN      = 27;

  logic        CLK;
  logic        nRST;
  csr_addr_t   csr_addr;
  csr_op_t     csr_op;
  csr_word_t   new_csr_val;
  priv_level_t priv_level;
  logic        inst_ret;
  logic [63:0] mtime;
  csr_word_t   old_csr_val;
  logic        invalid_csr;

  // Register model
  csr_word_t   m_mstatus;
  csr_word_t   m_mtvec;
  csr_word_t   m_mie;
  csr_word_t   m_mip;
  csr_word_t   m_mscratch;
  csr_word_t   m_mepc;
  csr_word_t   m_mcause;
  csr_word_t   m_mtval;
  csr_word_t   m_mcounteren;
  csr_word_t   m_mcountinhibit;
  logic [63:0] m_cycle;
  logic [63:0] m_instret;

  csr_addr_t   known_addrs [NUM_KNOWN];
  integer      seed;
  int          errors;
  int          checks;
  int          cycles = 0;

  tb_clock_gen u_clock_gen (.CLK(CLK), .nRST(nRST));

  csr_file #(.HARTID(TB_HARTID)) u_csr_file (
    .CLK(CLK), .nRST(nRST), .csr_addr(csr_addr), .csr_op(csr_op),
    .new_csr_val(new_csr_val), .priv_level(priv_level), .inst_ret(inst_ret),
    .mtime(mtime), .old_csr_val(old_csr_val), .invalid_csr(invalid_csr)
  );

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7FFF_FFFF) % n;
  endfunction

  // Only M and U may land in mpp
  function automatic csr_word_t legal_mstatus(input csr_word_t v);
    csr_word_t r;
    r = v & MSTATUS_MASK;
    if (r[12:11] inside {2'b01, 2'b10}) begin
      r[12:11] = 2'b00;
    end
    return r;
  endfunction

  function automatic csr_word_t legal_mtvec(input csr_word_t v);
    return {v[31:2], (v[1:0] == 2'b01) ? 2'b01 : 2'b00};
  endfunction

  function automatic logic expect_invalid(input csr_op_t op, input csr_addr_t a,
                                          input priv_level_t p, input logic unknown);
    logic modify;
    modify = (op == CSR_WRITE) || (op == CSR_SET) || (op == CSR_CLEAR);
    if (op == CSR_NONE) begin
      return 1'b0;
    end
    return (a[9:8] > p) || ((a[11:10] == 2'b11) && modify) || unknown;
  endfunction

  task automatic model_read(input csr_addr_t a, input priv_level_t p,
                            output csr_word_t v, output logic unknown);
    logic user;
    user    = (p == U_MODE);
    v       = '0;
    unknown = 1'b0;
    case (a)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR, MSTATUSH_ADDR: v = '0;
      MHARTID_ADDR:       v = TB_HARTID;
      MISA_ADDR:          v = MISA_VALUE;
      MSTATUS_ADDR:       v = m_mstatus;
      MTVEC_ADDR:         v = m_mtvec;
      MIE_ADDR:           v = m_mie;
      MIP_ADDR:           v = m_mip;
      MSCRATCH_ADDR:      v = m_mscratch;
      MEPC_ADDR:          v = m_mepc;
      MCAUSE_ADDR:        v = m_mcause;
      MTVAL_ADDR:         v = m_mtval;
      MCOUNTEREN_ADDR:    v = m_mcounteren;
      MCOUNTINHIBIT_ADDR: v = m_mcountinhibit;
      MCYCLE_ADDR, MCYCLEH_ADDR:     v = a[7] ? m_cycle[63:32] : m_cycle[31:0];
      MINSTRET_ADDR, MINSTRETH_ADDR: v = a[7] ? m_instret[63:32] : m_instret[31:0];
      CYCLE_ADDR, CYCLEH_ADDR: begin
        unknown = user && !m_mcounteren[0];
        v       = unknown ? '0 : (a[7] ? m_cycle[63:32] : m_cycle[31:0]);
      end
      TIME_ADDR, TIMEH_ADDR: begin
        unknown = user && !m_mcounteren[1];
        v       = unknown ? '0 : (a[7] ? mtime[63:32] : mtime[31:0]);
      end
      INSTRET_ADDR, INSTRETH_ADDR: begin
        unknown = user && !m_mcounteren[2];
        v       = unknown ? '0 : (a[7] ? m_instret[63:32] : m_instret[31:0]);
      end
      default: unknown = 1'b1;
    endcase
  endtask

  task automatic check_outputs();
    csr_word_t exp_val;
    logic      exp_unknown;
    logic      exp_inv;
    model_read(csr_addr, priv_level, exp_val, exp_unknown);
    exp_inv = expect_invalid(csr_op, csr_addr, priv_level, exp_unknown);
    checks += 2;
    assert (old_csr_val === exp_val) else begin
      errors += 1;
      $display("FAILED at time %0t: old_csr_val %h, expected %h (addr %h op %0d priv %0d)",
               $time, old_csr_val, exp_val, csr_addr, csr_op, priv_level);
    end
    assert (invalid_csr === exp_inv) else begin
      errors += 1;
      $display("FAILED at time %0t: invalid_csr %b, expected %b (addr %h op %0d priv %0d)",
               $time, invalid_csr, exp_inv, csr_addr, csr_op, priv_level);
    end
  endtask

  // Applies the inputs present at this edge to the model
  task automatic update_model();
    csr_word_t   old_val;
    logic        unknown;
    logic        wr;
    csr_word_t   data;
    logic [63:0] cycle_nx;
    logic [63:0] instret_nx;
    model_read(csr_addr, priv_level, old_val, unknown);
    wr = (csr_op inside {CSR_WRITE, CSR_SET, CSR_CLEAR})
         && !expect_invalid(csr_op, csr_addr, priv_level, unknown);
    case (csr_op)
      CSR_SET:   data = old_val | new_csr_val;
      CSR_CLEAR: data = old_val & ~new_csr_val;
      default:   data = new_csr_val;
    endcase
    cycle_nx   = m_cycle + (m_mcountinhibit[0] ? 64'd0 : 64'd1);
    instret_nx = m_instret + ((inst_ret && !m_mcountinhibit[2]) ? 64'd1 : 64'd0);
    if (wr) begin
      case (csr_addr)
        MSTATUS_ADDR:       m_mstatus       = legal_mstatus(data);
        MTVEC_ADDR:         m_mtvec         = legal_mtvec(data);
        MIE_ADDR:           m_mie           = data & MIX_MASK;
        MIP_ADDR:           m_mip           = data & MIX_MASK;
        MSCRATCH_ADDR:      m_mscratch      = data;
        MEPC_ADDR:          m_mepc          = data;
        MCAUSE_ADDR:        m_mcause        = data;
        MTVAL_ADDR:         m_mtval         = data;
        MCOUNTEREN_ADDR:    m_mcounteren    = data;
        MCOUNTINHIBIT_ADDR: m_mcountinhibit = data;
        MCYCLE_ADDR:        cycle_nx        = {m_cycle[63:32], data}; // Write beats increment
        MCYCLEH_ADDR:       cycle_nx        = {data, m_cycle[31:0]};
        MINSTRET_ADDR:      instret_nx      = {m_instret[63:32], data};
        MINSTRETH_ADDR:     instret_nx      = {data, m_instret[31:0]};
        default: begin
        end
      endcase
    end
    m_cycle   = cycle_nx;
    m_instret = instret_nx;
  endtask

  task automatic pick_stimulus(input int i);
    int        r;
    csr_word_t raw;
    if (i < NUM_KNOWN) begin
      // Reset value sweep in M mode
      csr_op      = CSR_READ;
      csr_addr    = known_addrs[i];
      priv_level  = M_MODE;
      new_csr_val = '0;
      inst_ret    = 1'b0;
    end else begin
      r = rand_below(16);
      if (r == 0) begin
        csr_op = CSR_NONE;
      end else if (r < 6) begin
        csr_op = CSR_READ;
      end else if (r < 11) begin
        csr_op = CSR_WRITE;
      end else if (r < 14) begin
        csr_op = CSR_SET;
      end else begin
        csr_op = CSR_CLEAR;
      end
      raw         = $random(seed);
      csr_addr    = (rand_below(16) == 0) ? raw[11:0] : known_addrs[rand_below(NUM_KNOWN)];
      new_csr_val = $random(seed);
      priv_level  = (rand_below(3) == 0) ? U_MODE : M_MODE;
      inst_ret    = (rand_below(2) == 1);
      // Counters keep running in the first half
      if (i < NUM_ACCESSES / 2 && csr_addr == MCOUNTINHIBIT_ADDR && csr_op != CSR_NONE) begin
        csr_op = CSR_READ;
      end
    end
    mtime = mtime + 64'(rand_below(3) + 1);
  endtask

  initial begin
    seed        = 32'ha32f7cf5;
    errors      = 0;
    checks      = 0;
    csr_op      = CSR_NONE;
    csr_addr    = '0;
    new_csr_val = '0;
    priv_level  = M_MODE;
    inst_ret    = 1'b0;
    mtime       = {$random(seed), $random(seed)};
    known_addrs = '{MSTATUS_ADDR, MISA_ADDR, MIE_ADDR, MTVEC_ADDR, MCOUNTEREN_ADDR,
                    MSTATUSH_ADDR, MCOUNTINHIBIT_ADDR, MSCRATCH_ADDR, MEPC_ADDR,
                    MCAUSE_ADDR, MTVAL_ADDR, MIP_ADDR, MCYCLE_ADDR, MINSTRET_ADDR,
                    MCYCLEH_ADDR, MINSTRETH_ADDR, MVENDORID_ADDR, MARCHID_ADDR,
                    MIMPID_ADDR, MHARTID_ADDR, MCONFIGPTR_ADDR, CYCLE_ADDR, TIME_ADDR,
                    INSTRET_ADDR, CYCLEH_ADDR, TIMEH_ADDR, INSTRETH_ADDR};
    m_mstatus       = MSTATUS_RESET;
    m_mtvec         = '0;
    m_mie           = '0;
    m_mip           = '0;
    m_mscratch      = '0;
    m_mepc          = '0;
    m_mcause        = '0;
    m_mtval         = '0;
    m_mcounteren    = MCOUNTEREN_RESET;
    m_mcountinhibit = '0;
    m_cycle         = '0;
    m_instret       = '0;

    wait (nRST === 1'b1);
    @(posedge CLK);
    update_model(); // Idle edge right after reset
    for (int i = 0; i < NUM_ACCESSES; i++) begin
      #2;
      pick_stimulus(i);
      #35;
      check_outputs(); // Settled, 3 ns before the edge
      @(posedge CLK);
      update_model();
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Clock and reset source for the CSR file testbench
// Free-running clock, active-low reset held over the first rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #2 nRST = 1'b1; // Released just after the edge
  end

endmodule

`default_nettype wire

// ==== src/csr_file.sv ====
// Top level of the machine-mode CSR file, one access per cycle, no back-pressure
// Connects the read mux, the access check and the two register blocks
`timescale 1ns/1ps
`default_nettype none

module csr_file import csr_pkg::*; #(
  parameter csr_word_t HARTID = '0
) (
  input  logic        CLK,
  input  logic        nRST,
  input  csr_addr_t   csr_addr,
  input  csr_op_t     csr_op,
  input  csr_word_t   new_csr_val,
  input  priv_level_t priv_level,
  input  logic        inst_ret,
  input  logic [63:0] mtime,
  output csr_word_t   old_csr_val,
  output logic        invalid_csr
);

  logic        addr_invalid;
  logic        wr_en;
  csr_word_t   wr_data;
  csr_word_t   mstatus;
  csr_word_t   mtvec;
  csr_word_t   mie;
  csr_word_t   mip;
  csr_word_t   mscratch;
  csr_word_t   mepc;
  csr_word_t   mcause;
  csr_word_t   mtval;
  csr_word_t   mcounteren;
  csr_word_t   mcountinhibit;
  logic [63:0] cycle_count;
  logic [63:0] instret_count;

  csr_read_mux #(.HARTID(HARTID)) u_read_mux (
    .csr_addr(csr_addr), .priv_level(priv_level),
    .mstatus(mstatus), .mtvec(mtvec), .mie(mie), .mip(mip),
    .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
    .mcounteren(mcounteren), .mcountinhibit(mcountinhibit),
    .cycle_count(cycle_count), .instret_count(instret_count), .mtime(mtime),
    .old_csr_val(old_csr_val), .addr_invalid(addr_invalid)
  );

  csr_access_check u_access_check (
    .csr_op(csr_op), .csr_addr(csr_addr), .new_csr_val(new_csr_val),
    .old_csr_val(old_csr_val), .priv_level(priv_level), .addr_invalid(addr_invalid),
    .wr_en(wr_en), .wr_data(wr_data), .invalid_csr(invalid_csr)
  );

  machine_trap_csrs u_trap_csrs (
    .CLK(CLK), .nRST(nRST), .wr_en(wr_en), .csr_addr(csr_addr), .wr_data(wr_data),
    .mstatus(mstatus), .mtvec(mtvec), .mie(mie), .mip(mip),
    .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval)
  );

  hpm_counters u_counters (
    .CLK(CLK), .nRST(nRST), .wr_en(wr_en), .csr_addr(csr_addr), .wr_data(wr_data),
    .inst_ret(inst_ret), .mcounteren(mcounteren), .mcountinhibit(mcountinhibit),
    .cycle_count(cycle_count), .instret_count(instret_count)
  );

endmodule

`default_nettype wire

// ==== src/csr_read_mux.sv ====
// Read decode for every implemented CSR address
// Flags unknown addresses and user counter reads blocked by mcounteren
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux import csr_pkg::*; #(
  parameter csr_word_t HARTID = '0
) (
  input  csr_addr_t   csr_addr,
  input  priv_level_t priv_level,
  input  csr_word_t   mstatus,
  input  csr_word_t   mtvec,
  input  csr_word_t   mie,
  input  csr_word_t   mip,
  input  csr_word_t   mscratch,
  input  csr_word_t   mepc,
  input  csr_word_t   mcause,
  input  csr_word_t   mtval,
  input  csr_word_t   mcounteren,
  input  csr_word_t   mcountinhibit,
  input  logic [63:0] cycle_count,
  input  logic [63:0] instret_count,
  input  logic [63:0] mtime,
  output csr_word_t   old_csr_val,
  output logic        addr_invalid
);

  logic user_mode;
  logic cy_blocked;
  logic tm_blocked;
  logic ir_blocked;

  assign user_mode  = (priv_level == U_MODE);
  assign cy_blocked = user_mode & ~mcounteren[0];
  assign tm_blocked = user_mode & ~mcounteren[1];
  assign ir_blocked = user_mode & ~mcounteren[2];

  always_comb begin
    old_csr_val  = '0;
    addr_invalid = 1'b0;
    case (csr_addr)
      // Info registers read as zero except hart id
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR: old_csr_val = '0;
      MHARTID_ADDR:       old_csr_val = HARTID;
      MSTATUSH_ADDR:      old_csr_val = '0; // Little endian only
      MISA_ADDR:          old_csr_val = MISA_VALUE;
      MSTATUS_ADDR:       old_csr_val = mstatus;
      MTVEC_ADDR:         old_csr_val = mtvec;
      MIE_ADDR:           old_csr_val = mie;
      MIP_ADDR:           old_csr_val = mip;
      MSCRATCH_ADDR:      old_csr_val = mscratch;
      MEPC_ADDR:          old_csr_val = mepc;
      MCAUSE_ADDR:        old_csr_val = mcause;
      MTVAL_ADDR:         old_csr_val = mtval;
      MCOUNTEREN_ADDR:    old_csr_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_csr_val = mcountinhibit;
      MCYCLE_ADDR:        old_csr_val = cycle_count[31:0];
      MCYCLEH_ADDR:       old_csr_val = cycle_count[63:32];
      MINSTRET_ADDR:      old_csr_val = instret_count[31:0];
      MINSTRETH_ADDR:     old_csr_val = instret_count[63:32];
      // User shadows, gated by mcounteren in U mode
      CYCLE_ADDR: begin
        addr_invalid = cy_blocked;
        old_csr_val  = cy_blocked ? '0 : cycle_count[31:0];
      end
      CYCLEH_ADDR: begin
        addr_invalid = cy_blocked;
        old_csr_val  = cy_blocked ? '0 : cycle_count[63:32];
      end
      TIME_ADDR: begin
        addr_invalid = tm_blocked;
        old_csr_val  = tm_blocked ? '0 : mtime[31:0];
      end
      TIMEH_ADDR: begin
        addr_invalid = tm_blocked;
        old_csr_val  = tm_blocked ? '0 : mtime[63:32];
      end
      INSTRET_ADDR: begin
        addr_invalid = ir_blocked;
        old_csr_val  = ir_blocked ? '0 : instret_count[31:0];
      end
      INSTRETH_ADDR: begin
        addr_invalid = ir_blocked;
        old_csr_val  = ir_blocked ? '0 : instret_count[63:32];
      end
      default: addr_invalid = 1'b1; // Not implemented
    endcase
  end

endmodule

`default_nettype wire

// ==== src/hpm_counters.sv ====
// Counter enable and inhibit registers plus the 64-bit cycle and instret counters
// Counters free-run every edge; a software write to one half wins at that edge
`timescale 1ns/1ps
`default_nettype none

module hpm_counters import csr_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        wr_en,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   wr_data,
  input  logic        inst_ret,
  output csr_word_t   mcounteren,
  output csr_word_t   mcountinhibit,
  output logic [63:0] cycle_count,
  output logic [63:0] instret_count
);

  logic        wr_mcycle;
  logic        wr_mcycleh;
  logic        wr_minstret;
  logic        wr_minstreth;
  logic [63:0] cycle_next;
  logic [63:0] instret_next;

  // Increment, then let a half-word write replace its half
  function automatic logic [63:0] count_next(
    input logic [63:0] count,
    input logic        inc,
    input logic        wr_lo,
    input logic        wr_hi,
    input csr_word_t   data
  );
    logic [63:0] result;
    result = count + {63'd0, inc};
    if (wr_lo) begin
      result = {count[63:32], data};
    end
    if (wr_hi) begin
      result = {data, count[31:0]};
    end
    return result;
  endfunction

  assign wr_mcycle    = wr_en && (csr_addr == MCYCLE_ADDR);
  assign wr_mcycleh   = wr_en && (csr_addr == MCYCLEH_ADDR);
  assign wr_minstret  = wr_en && (csr_addr == MINSTRET_ADDR);
  assign wr_minstreth = wr_en && (csr_addr == MINSTRETH_ADDR);

  // Inhibit bit 0 stops cycle, bit 2 stops instret
  assign cycle_next   = count_next(cycle_count, ~mcountinhibit[0],
                                   wr_mcycle, wr_mcycleh, wr_data);
  assign instret_next = count_next(instret_count, inst_ret & ~mcountinhibit[2],
                                   wr_minstret, wr_minstreth, wr_data);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcounteren    <= MCOUNTEREN_RESET;
      mcountinhibit <= '0;
      cycle_count   <= '0;
      instret_count <= '0;
    end else begin
      cycle_count   <= cycle_next;
      instret_count <= instret_next;
      if (wr_en && csr_addr == MCOUNTEREN_ADDR) begin
        mcounteren <= wr_data;
      end
      if (wr_en && csr_addr == MCOUNTINHIBIT_ADDR) begin
        mcountinhibit <= wr_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/machine_trap_csrs.sv ====
// Trap setup and trap handling registers with write legalization
// Written through the common wr_en / wr_data strobe, each address decoded here
`timescale 1ns/1ps
`default_nettype none

module machine_trap_csrs import csr_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      wr_en,
  input  csr_addr_t csr_addr,
  input  csr_word_t wr_data,
  output csr_word_t mstatus,
  output csr_word_t mtvec,
  output csr_word_t mie,
  output csr_word_t mip,
  output csr_word_t mscratch,
  output csr_word_t mepc,
  output csr_word_t mcause,
  output csr_word_t mtval
);

  csr_word_t    mstatus_legal;
  vector_mode_t mtvec_mode;

  // Only M and U exist, anything else in mpp falls back to U
  always_comb begin
    mstatus_legal = wr_data & MSTATUS_MASK;
    if (wr_data[12:11] == S_MODE || wr_data[12:11] == RESERVED_MODE) begin
      mstatus_legal[12:11] = U_MODE;
    end
  end

  assign mtvec_mode = (wr_data[1:0] > 2'b01) ? DIRECT : vector_mode_t'(wr_data[1:0]);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus  <= MSTATUS_RESET;
      mtvec    <= '0;
      mie      <= '0;
      mip      <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (wr_en) begin
      case (csr_addr)
        MSTATUS_ADDR:  mstatus  <= mstatus_legal;
        MTVEC_ADDR:    mtvec    <= {wr_data[31:2], mtvec_mode};
        MIE_ADDR:      mie      <= wr_data & MIX_MASK;
        MIP_ADDR:      mip      <= wr_data & MIX_MASK; // Software view of pending bits
        MSCRATCH_ADDR: mscratch <= wr_data;
        MEPC_ADDR:     mepc     <= wr_data;
        MCAUSE_ADDR:   mcause   <= wr_data;
        MTVAL_ADDR:    mtval    <= wr_data;
        default: begin
          // Address belongs to another block
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/csr_access_check.sv ====
// Combines the operand with the old CSR value and checks privilege and read-only rules
// Produces the single write strobe used by both register blocks
`timescale 1ns/1ps
`default_nettype none

module csr_access_check import csr_pkg::*; (
  input  csr_op_t     csr_op,
  input  csr_addr_t   csr_addr,
  input  csr_word_t   new_csr_val,
  input  csr_word_t   old_csr_val,
  input  priv_level_t priv_level,
  input  logic        addr_invalid,
  output logic        wr_en,
  output csr_word_t   wr_data,
  output logic        invalid_csr
);

  logic is_access;
  logic is_modify;
  logic priv_fault;
  logic ro_fault;
  logic any_fault;

  assign is_access = (csr_op != CSR_NONE);

  // Operand combine per operation
  always_comb begin
    is_modify = 1'b1;
    case (csr_op)
      CSR_WRITE: wr_data = new_csr_val;
      CSR_SET:   wr_data = old_csr_val | new_csr_val;
      CSR_CLEAR: wr_data = old_csr_val & ~new_csr_val;
      default: begin
        wr_data   = new_csr_val;
        is_modify = 1'b0;
      end
    endcase
  end

  // Bits 9:8 hold the lowest privilege allowed
  assign priv_fault = (csr_addr[9:8] > priv_level);

  // Top quarter of the space is read only
  assign ro_fault = (&csr_addr[11:10]) & is_modify;

  assign any_fault = priv_fault | ro_fault | addr_invalid;

  assign invalid_csr = is_access & any_fault;
  assign wr_en       = is_modify & ~any_fault;

endmodule

`default_nettype wire

// ==== src/csr_pkg.sv ====
// Shared widths, enums, CSR addresses and reset values for the machine-mode CSR file
// Imported by every CSR block and by the testbench
`default_nettype none

package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] csr_word_t;
  typedef logic [11:0]     csr_addr_t;

  typedef enum logic [2:0] {
    CSR_NONE  = 3'd0, // Idle cycle
    CSR_READ  = 3'd1,
    CSR_WRITE = 3'd2,
    CSR_SET   = 3'd3,
    CSR_CLEAR = 3'd4
  } csr_op_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vector_mode_t;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  // Machine counters
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  // Machine information, read only
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;
  // User counter shadows
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t TIME_ADDR          = 12'hC01;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t TIMEH_ADDR         = 12'hC81;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;

  localparam csr_word_t MISA_VALUE       = 32'h4010_1100; // MXL=1, I, M, U
  localparam csr_word_t MSTATUS_RESET    = 32'h0020_0000; // tw set, mpp = U
  localparam csr_word_t MSTATUS_MASK     = 32'h0022_1888; // mie mpie mpp mprv tw
  localparam csr_word_t MIX_MASK         = 32'h0000_0888; // Software, timer, external
  localparam csr_word_t MCOUNTEREN_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire
